//--- all.f
common/mipsPkg.sv
mipsCore/controlUnit.sv
mipsCore/aluUnit.sv
mipsCore/regFile.sv
mipsCore/pcUnit.sv
mipsCore/mipsCore.sv
dv/mipsProps.sv
dv/mipsTb.sv

//--- dv/mipsTb.sv
// ====================
// testbench for the single-cycle MIPS core
// clock, reset, LFSR program builder
// instruction and data memory models
// reference model and per-cycle compare
// ====================

`timescale 1ns/1ps

module mipsTb import mipsPkg::*; ();

  logic clk = 1'b0;
  logic rst;
  logic [xlen-1:0] instAddr;
  logic [xlen-1:0] instr;
  logic [dataAddrWidth-1:0] memAddr;
  logic [xlen-1:0] memWriteData;
  logic memWrite;
  logic memRead;
  logic [xlen-1:0] memReadData;
  logic wbEn;
  logic [regAddrWidth-1:0] wbAddr;
  logic [xlen-1:0] wbData;

  // memories and shadow state
  logic [xlen-1:0] instrMem [128];
  logic [xlen-1:0] dataMem [128];
  logic [xlen-1:0] shadowMem [128];
  logic [xlen-1:0] shadowRegs [32];
  logic [xlen-1:0] shadowPc = '0;
  logic [xlen-1:0] loopAddr;
  logic [31:0] lfsr = 32'hf6511fc5;
  int fillPos;
  int progLen;
  int cycleLimit = 1000;
  int cycleCount = 0;

  mipsCore dut_i (
    .clk          (clk),
    .rst          (rst),
    .instAddr     (instAddr),
    .instr        (instr),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memWrite     (memWrite),
    .memRead      (memRead),
    .memReadData  (memReadData),
    .wbEn         (wbEn),
    .wbAddr       (wbAddr),
    .wbData       (wbData)
  );

  // ====================
  // memory models
  // ====================

  // word index out of the byte address
  assign instr = instrMem[instAddr[8:2]];
  assign memReadData = dataMem[memAddr];

  always @(posedge clk) begin
    if (memWrite) begin
      dataMem[memAddr] <= memWriteData;
    end
  end

  // ====================
  // program generation
  // ====================

  // galois form with taps of x^32+x^22+x^2+x+1
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = nextLfsr(lfsr);
    end
    return v;
  endfunction

  function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
      input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
    instrWord w;
    w.rFmt = '{opRType, rs, rt, rd, sh, fn};
    return w;
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
      input logic [4:0] rt, input logic [15:0] imm);
    instrWord w;
    w.iFmt = '{op, rs, rt, imm};
    return w;
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
    instrWord w;
    w.jFmt = '{op, target};
    return w;
  endfunction

  function automatic void putInstr(input logic [31:0] w);
    instrMem[fillPos] = w;
    fillPos++;
    progLen++;
  endfunction

  task automatic buildProgram();
    logic [5:0] fnList [7];
    logic [5:0] fn;
    logic [4:0] rt;
    logic [6:0] addr;
    int top;
    fnList = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSll, fnSrl};
    fillPos = 0;
    progLen = 0;
    for (int i = 0; i < 128; i++) begin
      instrMem[i] = '0;
      // fill mixes every address bit
      dataMem[i] = (i * 32'h01010193) ^ 32'h5a5a0000;
      shadowMem[i] = dataMem[i];
    end
    for (int i = 0; i < 32; i++) begin
      shadowRegs[i] = '0;
    end
    // random immediates into r1..r8
    for (int r = 1; r <= 8; r++) begin
      putInstr(encodeI(opAddi, 5'd0, 5'(r), 16'(takeBits(16))));
    end
    // random R-type ops over r1..r8
    for (int k = 0; k < 16; k++) begin
      fn = fnList[takeBits(3) % 7];
      putInstr(encodeR(fn, 5'(takeBits(3) + 1), 5'(takeBits(3) + 1), 5'(takeBits(3) + 1),
                       (fn == fnSll || fn == fnSrl) ? 5'(takeBits(5)) : 5'd0));
    end
    // r0 writes dropped, r0 reads zero
    putInstr(encodeI(opAddi, 5'd1, 5'd0, 16'h1234));
    putInstr(encodeR(fnAdd, 5'd2, 5'd3, 5'd0, 5'd0));
    putInstr(encodeR(fnOr, 5'd0, 5'd4, 5'd9, 5'd0));
    putInstr(encodeR(fnAdd, 5'd0, 5'd0, 5'd10, 5'd0));
    // store then load, plus the neighbour word
    for (int k = 0; k < 5; k++) begin
      addr = 7'(takeBits(7));
      rt = 5'(takeBits(3) + 1);
      putInstr(encodeI(opAddi, 5'd0, 5'd10, {7'd0, addr, 2'b00}));
      putInstr(encodeI(opSw, 5'd10, rt, 16'd0));
      putInstr(encodeI(opLw, 5'd10, 5'd11, 16'd0));
      putInstr(encodeI(opLw, 5'd10, 5'd12, 16'd4));
    end
    // forward beq taken and then data dependent
    putInstr(encodeI(opBeq, 5'd1, 5'd1, 16'd1));
    putInstr(encodeI(opAddi, 5'd0, 5'd12, 16'd1));
    putInstr(encodeI(opBeq, 5'd1, 5'd2, 16'd1));
    putInstr(encodeI(opAddi, 5'd0, 5'd12, 16'd2));
    // countdown loop with a backward beq
    putInstr(encodeI(opAddi, 5'd0, 5'd13, 16'd3));
    top = fillPos;
    putInstr(encodeI(opAddi, 5'd13, 5'd13, 16'hffff));
    putInstr(encodeI(opBeq, 5'd13, 5'd0, 16'd1));
    putInstr(encodeI(opBeq, 5'd0, 5'd0, 16'(top - fillPos - 1)));
    // j over one word, then call and return
    putInstr(encodeJ(opJ, 26'(fillPos + 2)));
    putInstr(encodeI(opAddi, 5'd0, 5'd12, 16'd3));
    putInstr(encodeJ(opJal, 26'd120));
    putInstr(encodeR(fnAdd, 5'd14, 5'd31, 5'd15, 5'd0));
    loopAddr = fillPos * 4;
    putInstr(encodeJ(opJ, 26'(fillPos)));
    // subroutine far up in memory
    fillPos = 120;
    putInstr(encodeI(opAddi, 5'd14, 5'd14, 16'd7));
    putInstr(encodeR(fnJr, 5'd31, 5'd0, 5'd0, 5'd0));
    cycleLimit = 2 * progLen + 5 + 20;
  endtask

  // ====================
  // reference and compare
  // ====================

  // one instruction on the shadow state
  function automatic void referenceStep(input logic [31:0] word, output logic [31:0] nextPc,
      output logic wbExp, output logic [4:0] wbAddrExp, output logic [31:0] wbDataExp,
      output logic loadExp, output logic storeExp, output logic [6:0] storeAddrExp,
      output logic [31:0] storeDataExp);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] pc4;
    logic [31:0] ea;
    logic wr;
    logic [4:0] dest;
    logic [31:0] val;
    a = shadowRegs[word[25:21]];
    b = shadowRegs[word[20:16]];
    imm = {{16{word[15]}}, word[15:0]};
    pc4 = shadowPc + 32'd4;
    ea = a + imm;
    nextPc = pc4;
    wr = 1'b0;
    dest = word[20:16];
    val = '0;
    loadExp = 1'b0;
    storeExp = 1'b0;
    storeAddrExp = ea[8:2];
    storeDataExp = b;
    case (word[31:26])
      opRType: begin
        wr = 1'b1;
        dest = word[15:11];
        case (word[5:0])
          fnAdd: val = a + b;
          fnSub: val = a - b;
          fnAnd: val = a & b;
          fnOr:  val = a | b;
          fnSlt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fnSll: val = b << word[10:6];
          fnSrl: val = b >> word[10:6];
          fnJr: begin
            wr = 1'b0;
            nextPc = a;
          end
          default: wr = 1'b0;
        endcase
      end
      opAddi: begin
        wr = 1'b1;
        val = ea;
      end
      opLw: begin
        wr = 1'b1;
        loadExp = 1'b1;
        val = shadowMem[ea[8:2]];
      end
      opSw: storeExp = 1'b1;
      // offset counts words from pc+4
      opBeq: nextPc = (a == b) ? pc4 + {imm[29:0], 2'b00} : pc4;
      opJ: nextPc = {pc4[31:28], word[25:0], 2'b00};
      opJal: begin
        nextPc = {pc4[31:28], word[25:0], 2'b00};
        wr = 1'b1;
        dest = linkReg;
        val = pc4;
      end
      default: ;
    endcase
    wbExp = wr && (dest != 5'd0);
    wbAddrExp = dest;
    wbDataExp = val;
    if (wbExp) begin
      shadowRegs[dest] = val;
    end
    if (storeExp) begin
      shadowMem[ea[8:2]] = b;
    end
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  initial begin
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b0;
    buildProgram();
    repeat (5) @(posedge clk);
    #1 rst = 1'b1;
  end

  // bound on the run length
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("timeout: the final loop was not reached within %0d cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $fatal(1, "cycle limit reached");
    end
  end

  // compare mid-cycle when outputs have settled
  initial begin : compare
    logic [31:0] nextPc;
    logic wbExp;
    logic [4:0] wbAddrExp;
    logic [31:0] wbDataExp;
    logic loadExp;
    logic storeExp;
    logic [6:0] storeAddrExp;
    logic [31:0] storeDataExp;
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (dut_i.props_i.failCount != 0) begin
        $display("an assertion on the core ports failed before %0t", $time);
        $display("*** TEST FAILED ***");
        $fatal(1, "assertion failure");
      end
      if (!rst) begin
        checkValue("instAddr", instAddr, 32'd0);
        checkValue("wbEn", wbEn, 32'd0);
        checkValue("memWrite", memWrite, 32'd0);
      end else begin
        checkValue("instAddr", instAddr, shadowPc);
        if (shadowPc == loopAddr) begin
          done = 1'b1;
        end else begin
          referenceStep(instrMem[shadowPc[8:2]], nextPc, wbExp, wbAddrExp, wbDataExp,
                        loadExp, storeExp, storeAddrExp, storeDataExp);
          checkValue("wbEn", wbEn, wbExp);
          if (wbExp) begin
            checkValue("wbAddr", wbAddr, wbAddrExp);
            checkValue("wbData", wbData, wbDataExp);
          end
          checkValue("memRead", memRead, loadExp);
          checkValue("memWrite", memWrite, storeExp);
          if (storeExp) begin
            checkValue("memAddr", memAddr, storeAddrExp);
            checkValue("memWriteData", memWriteData, storeDataExp);
          end
          shadowPc = nextPc;
        end
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- dv/mipsProps.sv
// ====================
// concurrent checks on the core ports
// fetch alignment, load/store exclusion
// no writeback to r0, quiet during reset
// ====================

`timescale 1ns/1ps

module mipsProps import mipsPkg::*; (
  input logic                    clk,
  input logic                    rst,
  input logic [xlen-1:0]         instAddr,
  input logic                    memWrite,
  input logic                    memRead,
  input logic                    wbEn,
  input logic [regAddrWidth-1:0] wbAddr
);

  // failed assertions so far
  int failCount = 0;

  // out of reset the fetch address is a whole word
  alignedFetch: assert property (@(posedge clk) disable iff (!rst) instAddr[1:0] == 2'b00)
    else begin
      $error("instAddr %h is not word aligned", instAddr);
      failCount++;
    end

  // one instruction is either a load or a store
  loadStoreExclusive: assert property (@(posedge clk) !(memWrite && memRead))
    else begin
      $error("memWrite and memRead high together");
      failCount++;
    end

  noWriteToZero: assert property (@(posedge clk) wbEn |-> (wbAddr != '0))
    else begin
      $error("wbEn high with wbAddr 0");
      failCount++;
    end

  // nothing committed while rst is low
  quietInReset: assert property (@(posedge clk) !rst |-> (!memWrite && !wbEn))
    else begin
      $error("memWrite or wbEn high during reset");
      failCount++;
    end

endmodule

bind mipsCore mipsProps props_i (
  .clk      (clk),
  .rst      (rst),
  .instAddr (instAddr),
  .memWrite (memWrite),
  .memRead  (memRead),
  .wbEn     (wbEn),
  .wbAddr   (wbAddr)
);

//--- mipsCore/mipsCore.sv
// ====================
// single-cycle MIPS core, top level
// control, ALU, register file, PC units
// immediate extension, destination select
// operand and writeback muxes
// ====================

`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  output logic [xlen-1:0]          instAddr,
  input  logic [xlen-1:0]          instr,
  output logic [dataAddrWidth-1:0] memAddr,
  output logic [xlen-1:0]          memWriteData,
  output logic                     memWrite,
  output logic                     memRead,
  input  logic [xlen-1:0]          memReadData,
  output logic                     wbEn,
  output logic [regAddrWidth-1:0]  wbAddr,
  output logic [xlen-1:0]          wbData
);

  // ====================
  // decode
  // ====================

  instrWord instrU;

  logic regDst;
  logic aluSrc;
  logic memToReg;
  logic link;
  logic regWrite;
  logic memReadCtl;
  logic memWriteCtl;
  logic branch;
  logic jump;
  logic jumpReg;
  logic shiftOp;
  logic signExt;
  logic [3:0] aluOp;

  logic [xlen-1:0] immExt;
  logic [xlen-1:0] readDataA;
  logic [xlen-1:0] readDataB;
  logic [xlen-1:0] aluB;
  logic [4:0] aluShamt;
  logic [xlen-1:0] aluResult;
  logic zero;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pcPlus4;

  assign instrU = instr;

  controlUnit ctrl_i (
    .instr    (instrU),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .link     (link),
    .regWrite (regWrite),
    .memRead  (memReadCtl),
    .memWrite (memWriteCtl),
    .branch   (branch),
    .jump     (jump),
    .jumpReg  (jumpReg),
    .shiftOp  (shiftOp),
    .signExt  (signExt),
    .aluOp    (aluOp)
  );

  // sign or zero extension of the 16-bit immediate
  assign immExt = {{16{signExt & instrU.iFmt.imm[15]}}, instrU.iFmt.imm};

  // ====================
  // execute
  // ====================

  regFile regs_i (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (wbEn),
    .readAddrA (instrU.rFmt.rs),
    .readAddrB (instrU.rFmt.rt),
    .writeAddr (wbAddr),
    .writeData (wbData),
    .readDataA (readDataA),
    .readDataB (readDataB)
  );

  assign aluB = aluSrc ? immExt : readDataB;
  // shamt field only counts for sll and srl
  assign aluShamt = shiftOp ? instrU.rFmt.shamt : 5'd0;

  aluUnit alu_i (
    .a      (readDataA),
    .b      (aluB),
    .shamt  (aluShamt),
    .aluOp  (aluOp),
    .result (aluResult),
    .zero   (zero)
  );

  pcUnit pc_i (
    .clk          (clk),
    .rst          (rst),
    .branch       (branch),
    .zero         (zero),
    .jump         (jump),
    .jumpReg      (jumpReg),
    .branchOffset (immExt),
    .jumpTarget   (instrU.jFmt.target),
    .regTarget    (readDataA),
    .pc           (pc),
    .pcPlus4      (pcPlus4)
  );

  // ====================
  // memory and writeback
  // ====================

  assign instAddr = pc;

  // word address out of the byte address
  assign memAddr      = aluResult[dataAddrWidth+1:2];
  assign memWriteData = readDataB;
  assign memRead      = memReadCtl;
  // no store leaves the core while in reset
  assign memWrite     = memWriteCtl & rst;

  // jal links to r31, R-type to rd, I-type to rt
  assign wbAddr = link ? linkReg : (regDst ? instrU.rFmt.rd : instrU.iFmt.rt);
  assign wbData = link ? pcPlus4 : (memToReg ? memReadData : aluResult);
  // writes to r0 are dropped here as well
  assign wbEn   = regWrite & rst & (wbAddr != '0);

endmodule

//--- mipsCore/pcUnit.sv
// ====================
// program counter register
// next address: register jump, jump, branch, pc+4
// ====================

`timescale 1ns/1ps

module pcUnit import mipsPkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            branch,
  input  logic            zero,
  input  logic            jump,
  input  logic            jumpReg,
  input  logic [xlen-1:0] branchOffset,
  input  logic [25:0]     jumpTarget,
  input  logic [xlen-1:0] regTarget,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] pcPlus4
);

  logic [xlen-1:0] nextPc;
  logic [xlen-1:0] branchAddr;
  logic [xlen-1:0] jumpAddr;

  assign pcPlus4 = pc + 32'd4;

  // word offset relative to the following instruction
  assign branchAddr = pcPlus4 + {branchOffset[xlen-3:0], 2'b00};
  // keep the 256 MB region of pc+4
  assign jumpAddr = {pcPlus4[xlen-1:28], jumpTarget, 2'b00};

  always_comb begin
    if (jumpReg) begin
      nextPc = regTarget;
    end else if (jump) begin
      nextPc = jumpAddr;
    end else if (branch && zero) begin
      nextPc = branchAddr;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

//--- mipsCore/regFile.sv
// ====================
// 32-entry register file
// two combinational reads, one write on the edge
// register 0 reads as zero
// ====================

`timescale 1ns/1ps

module regFile import mipsPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    writeEn,
  input  logic [regAddrWidth-1:0] readAddrA,
  input  logic [regAddrWidth-1:0] readAddrB,
  input  logic [regAddrWidth-1:0] writeAddr,
  input  logic [xlen-1:0]         writeData,
  output logic [xlen-1:0]         readDataA,
  output logic [xlen-1:0]         readDataB
);

  // only registers 1 to 31 exist
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int idx = 1; idx < 32; idx++) begin
        regs[idx] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // index 0 bypasses the array
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- mipsCore/aluUnit.sv
// ====================
// 32-bit ALU
// add, sub, and, or, signed slt
// logical shifts of b by shamt, zero flag
// ====================

`timescale 1ns/1ps

module aluUnit import mipsPkg::*; (
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  logic [4:0]      shamt,
  input  logic [3:0]      aluOp,
  output logic [xlen-1:0] result,
  output logic            zero
);

  always_comb begin
    case (aluOp)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // signed compare, result is 0 or 1
      aluSlt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      // shifts act on the rt operand
      aluSll: result = b << shamt;
      aluSrl: result = b >> shamt;
      default: result = '0;
    endcase
  end

  // flag for any operation, beq reads it after sub
  assign zero = (result == '0);

endmodule

//--- mipsCore/controlUnit.sv
// ====================
// main decoder of the core
// opcode and function code to datapath controls
// and the ALU operation, in a single level
// ====================

`timescale 1ns/1ps

module controlUnit import mipsPkg::*; (
  input  instrWord   instr,
  output logic       regDst,
  output logic       aluSrc,
  output logic       memToReg,
  output logic       link,
  output logic       regWrite,
  output logic       memRead,
  output logic       memWrite,
  output logic       branch,
  output logic       jump,
  output logic       jumpReg,
  output logic       shiftOp,
  output logic       signExt,
  output logic [3:0] aluOp
);

  always_comb begin
    // defaults: nothing written, nothing taken
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    link     = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    jumpReg  = 1'b0;
    shiftOp  = 1'b0;
    signExt  = 1'b0;
    aluOp    = aluAdd;
    case (instr.rFmt.opcode)
      opRType: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (instr.rFmt.funct)
          fnAdd: aluOp = aluAdd;
          fnSub: aluOp = aluSub;
          fnAnd: aluOp = aluAnd;
          fnOr:  aluOp = aluOr;
          fnSlt: aluOp = aluSlt;
          fnSll: begin
            aluOp   = aluSll;
            shiftOp = 1'b1;
          end
          fnSrl: begin
            aluOp   = aluSrl;
            shiftOp = 1'b1;
          end
          fnJr: begin
            // register jump, no writeback
            regWrite = 1'b0;
            jumpReg  = 1'b1;
          end
          // unknown function code
          default: regWrite = 1'b0;
        endcase
      end
      opAddi: begin
        aluSrc   = 1'b1;
        signExt  = 1'b1;
        regWrite = 1'b1;
      end
      opLw: begin
        aluSrc   = 1'b1;
        signExt  = 1'b1;
        memToReg = 1'b1;
        memRead  = 1'b1;
        regWrite = 1'b1;
      end
      opSw: begin
        aluSrc   = 1'b1;
        signExt  = 1'b1;
        memWrite = 1'b1;
      end
      opBeq: begin
        // compare by subtraction, zero flag decides
        aluOp   = aluSub;
        signExt = 1'b1;
        branch  = 1'b1;
      end
      opJ: jump = 1'b1;
      opJal: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- common/mipsPkg.sv
// ====================
// shared definitions for the single-cycle MIPS core
// datapath and register index widths
// opcode and function code encodings
// ALU operation codes, link register index
// instruction word union over R, I and J formats
// ====================

package mipsPkg;

  // widths
  localparam int xlen = 32;
  localparam int regAddrWidth = 5;
  // 128-word data memory
  localparam int dataAddrWidth = 7;

  // opcodes
  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opJal   = 6'h03;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opAddi  = 6'h08;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;

  // function codes, R-type only
  localparam logic [5:0] fnSll = 6'h00;
  localparam logic [5:0] fnSrl = 6'h02;
  localparam logic [5:0] fnJr  = 6'h08;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // ALU operation codes
  localparam logic [3:0] aluAnd = 4'b0000;
  localparam logic [3:0] aluOr  = 4'b0001;
  localparam logic [3:0] aluAdd = 4'b0010;
  localparam logic [3:0] aluSub = 4'b0110;
  localparam logic [3:0] aluSlt = 4'b0111;
  localparam logic [3:0] aluSll = 4'b1000;
  localparam logic [3:0] aluSrl = 4'b1001;

  // jal destination
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } rFmt;
    struct packed {
      logic [5:0] opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [15:0] imm;
    } iFmt;
    struct packed {
      logic [5:0] opcode;
      logic [25:0] target;
    } jFmt;
  } instrWord;

endpackage
